// File: rtl/pool_pkg.sv
// Pooling engine shared types

package pool_pkg;

    // ==================================================
    // Widths
    // ==================================================

    // Buffer addresses and neighbour indices
    localparam int IDX_WIDTH = 16;

    // One activation lane
    localparam int ACT_WIDTH = 8;

    // One neighbour-map word from the global buffer
    localparam int MAP_WIDTH = 256;

    // Indices per map word, also the largest K
    localparam int MAX_K = MAP_WIDTH / IDX_WIDTH;

    // ==================================================
    // Types
    // ==================================================

    typedef logic [IDX_WIDTH-1:0] idx_t;

    typedef logic [ACT_WIDTH-1:0] act_t;

    // Index 0 sits in the low bits
    typedef idx_t [MAX_K-1:0] map_word_t;

    // Neighbour count, 1 to MAX_K
    typedef logic [$clog2(MAX_K+1)-1:0] k_t;

    // Job control FSM
    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } pool_state_e;

endpackage

// File: rtl/pool_cfg_if.sv
// Pooling job configuration bundle
`timescale 1ns/1ps

interface pool_cfg_if;
    import pool_pkg::*;

    // Latched job fields
    idx_t num_points;
    k_t   k;
    idx_t map_base;
    idx_t ofm_rd_base;
    idx_t ofm_wr_base;

    // Job status
    logic run;
    logic fetch_done;
    logic write_done;

    modport ctrl (
        output num_points,
        output k,
        output map_base,
        output ofm_rd_base,
        output ofm_wr_base,
        output run,
        input  write_done
    );

    modport dp (
        input  num_points,
        input  k,
        input  map_base,
        input  ofm_rd_base,
        input  ofm_wr_base,
        input  run,
        output fetch_done,
        output write_done
    );

endinterface

// File: rtl/pool_ctrl.sv
// Pooling job control
`timescale 1ns/1ps

module pool_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cfg_valid,
    output logic           cfg_ready,
    input  pool_pkg::idx_t cfg_num_points,
    input  pool_pkg::k_t   cfg_k,
    input  pool_pkg::idx_t cfg_map_base,
    input  pool_pkg::idx_t cfg_ofm_rd_base,
    input  pool_pkg::idx_t cfg_ofm_wr_base,
    pool_cfg_if.ctrl       cfg
);
    import pool_pkg::*;

    pool_state_e state;
    pool_state_e state_nxt;
    logic        cfg_hs;

    idx_t num_points_q;
    k_t   k_q;
    idx_t map_base_q;
    idx_t ofm_rd_base_q;
    idx_t ofm_wr_base_q;

    // ==================================================
    // Job FSM
    // ==================================================

    assign cfg_ready = (state == IDLE);
    assign cfg_hs    = cfg_valid && cfg_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (cfg_hs) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                // Job ends on the last output write only
                if (cfg.write_done) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ==================================================
    // Configuration latch
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num_points_q  <= '0;
            k_q           <= '0;
            map_base_q    <= '0;
            ofm_rd_base_q <= '0;
            ofm_wr_base_q <= '0;
        end else if (cfg_hs) begin
            num_points_q  <= cfg_num_points;
            k_q           <= cfg_k;
            map_base_q    <= cfg_map_base;
            ofm_rd_base_q <= cfg_ofm_rd_base;
            ofm_wr_base_q <= cfg_ofm_wr_base;
        end
    end

    assign cfg.num_points  = num_points_q;
    assign cfg.k           = k_q;
    assign cfg.map_base    = map_base_q;
    assign cfg.ofm_rd_base = ofm_rd_base_q;
    assign cfg.ofm_wr_base = ofm_wr_base_q;
    assign cfg.run         = (state == RUN);

endmodule

// File: rtl/pool_map_reader.sv
// Neighbour map fetch and feature read issue
`timescale 1ns/1ps

module pool_map_reader (
    input  logic                clk,
    input  logic                rst_n,
    pool_cfg_if.dp              cfg,
    output pool_pkg::idx_t      map_rd_addr,
    output logic                map_rd_addr_valid,
    input  logic                map_rd_addr_ready,
    input  pool_pkg::map_word_t map_rd_data,
    input  logic                map_rd_data_valid,
    output logic                map_rd_data_ready,
    output pool_pkg::idx_t      ofm_rd_addr,
    output logic                ofm_rd_addr_valid,
    input  logic                ofm_rd_addr_ready
);
    import pool_pkg::*;

    localparam int NB_W = $clog2(MAX_K);

    // Phase flags, at most one set during a job
    logic map_req;
    logic map_wait;
    logic nb_active;
    logic fetch_done;

    idx_t            point_cnt;
    logic [NB_W-1:0] nb_cnt;
    map_word_t       map_buf;

    logic map_addr_hs;
    logic map_data_hs;
    logic ofm_addr_hs;
    logic last_nb;
    logic last_point;
    logic job_start;

    // ==================================================
    // Handshakes and terminal counts
    // ==================================================

    assign map_addr_hs = map_req && map_rd_addr_ready;
    assign map_data_hs = map_wait && map_rd_data_valid;
    assign ofm_addr_hs = nb_active && ofm_rd_addr_ready;

    assign last_nb    = (k_t'(nb_cnt) == cfg.k - k_t'(1));
    assign last_point = (point_cnt == cfg.num_points - idx_t'(1));

    // First cycle of a job, nothing issued yet
    assign job_start = !(map_req || map_wait || nb_active || fetch_done);

    // ==================================================
    // Fetch sequencing
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map_req    <= 1'b0;
            map_wait   <= 1'b0;
            nb_active  <= 1'b0;
            fetch_done <= 1'b0;
            point_cnt  <= '0;
            nb_cnt     <= '0;
        end else if (!cfg.run) begin
            map_req    <= 1'b0;
            map_wait   <= 1'b0;
            nb_active  <= 1'b0;
            fetch_done <= 1'b0;
            point_cnt  <= '0;
            nb_cnt     <= '0;
        end else begin
            if (job_start) begin
                map_req <= 1'b1;
            end

            if (map_addr_hs) begin
                map_req  <= 1'b0;
                map_wait <= 1'b1;
            end

            // Single outstanding read, so data is taken on arrival
            if (map_data_hs) begin
                map_wait  <= 1'b0;
                nb_active <= 1'b1;
                nb_cnt    <= '0;
            end

            if (ofm_addr_hs) begin
                if (last_nb) begin
                    nb_active <= 1'b0;
                    nb_cnt    <= '0;
                    if (last_point) begin
                        fetch_done <= 1'b1;
                    end else begin
                        point_cnt <= point_cnt + idx_t'(1);
                        map_req   <= 1'b1;
                    end
                end else begin
                    nb_cnt <= nb_cnt + 1'b1;
                end
            end
        end
    end

    // Map word holding register
    always_ff @(posedge clk) begin
        if (map_data_hs) begin
            map_buf <= map_rd_data;
        end
    end

    // ==================================================
    // Outputs
    // ==================================================

    assign map_rd_addr       = cfg.map_base + point_cnt;
    assign map_rd_addr_valid = map_req;
    assign map_rd_data_ready = map_wait;

    assign ofm_rd_addr       = cfg.ofm_rd_base + map_buf[nb_cnt];
    assign ofm_rd_addr_valid = nb_active;

    assign cfg.fetch_done = fetch_done;

endmodule

// File: rtl/pool_max_unit.sv
// Lane-wise max reduction and output write
`timescale 1ns/1ps

module pool_max_unit #(
    parameter int LANES = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    pool_cfg_if.dp                     cfg,
    input  pool_pkg::act_t [LANES-1:0] ofm_rd_data,
    input  logic                       ofm_rd_data_valid,
    output logic                       ofm_rd_data_ready,
    output pool_pkg::idx_t             ofm_wr_addr,
    output pool_pkg::act_t [LANES-1:0] ofm_wr_data,
    output logic                       ofm_wr_valid,
    input  logic                       ofm_wr_ready
);
    import pool_pkg::*;

    localparam int NB_W = $clog2(MAX_K);

    logic [NB_W-1:0]   row_cnt;
    idx_t              point_cnt;
    act_t [LANES-1:0]  max_row;
    act_t [LANES-1:0]  next_row;
    logic              wr_last;

    logic row_hs;
    logic wr_hs;
    logic last_row;
    logic wr_stall;

    // ==================================================
    // Handshakes
    // ==================================================

    // Pending write blocks row intake
    assign wr_stall          = ofm_wr_valid && !ofm_wr_ready;
    assign ofm_rd_data_ready = cfg.run && !wr_stall;

    assign row_hs   = ofm_rd_data_valid && ofm_rd_data_ready;
    assign wr_hs    = ofm_wr_valid && ofm_wr_ready;
    assign last_row = (k_t'(row_cnt) == cfg.k - k_t'(1));

    // ==================================================
    // Max datapath
    // ==================================================

    // First row of a point loads, later rows compare
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (row_cnt == '0) begin
                next_row[i] = ofm_rd_data[i];
            end else if (ofm_rd_data[i] > max_row[i]) begin
                next_row[i] = ofm_rd_data[i];
            end else begin
                next_row[i] = max_row[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_hs) begin
            max_row <= next_row;
        end
        if (row_hs && last_row) begin
            ofm_wr_data <= next_row;
            ofm_wr_addr <= cfg.ofm_wr_base + point_cnt;
            wr_last     <= (point_cnt == cfg.num_points - idx_t'(1));
        end
    end

    // ==================================================
    // Row and point counters
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt      <= '0;
            point_cnt    <= '0;
            ofm_wr_valid <= 1'b0;
        end else if (!cfg.run) begin
            row_cnt      <= '0;
            point_cnt    <= '0;
            ofm_wr_valid <= 1'b0;
        end else begin
            if (wr_hs) begin
                ofm_wr_valid <= 1'b0;
            end
            if (row_hs) begin
                if (last_row) begin
                    row_cnt      <= '0;
                    point_cnt    <= point_cnt + idx_t'(1);
                    ofm_wr_valid <= 1'b1;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end
        end
    end

    // Pulse on the final write handshake of the job
    assign cfg.write_done = wr_hs && wr_last;

endmodule

// File: rtl/pool_top.sv
// Point-cloud max-pooling engine
`timescale 1ns/1ps

module pool_top #(
    parameter int LANES = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // Configuration
    input  logic                       cfg_valid,
    output logic                       cfg_ready,
    input  pool_pkg::idx_t             cfg_num_points,
    input  pool_pkg::k_t               cfg_k,
    input  pool_pkg::idx_t             cfg_map_base,
    input  pool_pkg::idx_t             cfg_ofm_rd_base,
    input  pool_pkg::idx_t             cfg_ofm_wr_base,

    // Neighbour map read
    output pool_pkg::idx_t             map_rd_addr,
    output logic                       map_rd_addr_valid,
    input  logic                       map_rd_addr_ready,
    input  pool_pkg::map_word_t        map_rd_data,
    input  logic                       map_rd_data_valid,
    output logic                       map_rd_data_ready,

    // Feature row read
    output pool_pkg::idx_t             ofm_rd_addr,
    output logic                       ofm_rd_addr_valid,
    input  logic                       ofm_rd_addr_ready,
    input  pool_pkg::act_t [LANES-1:0] ofm_rd_data,
    input  logic                       ofm_rd_data_valid,
    output logic                       ofm_rd_data_ready,

    // Result row write
    output pool_pkg::idx_t             ofm_wr_addr,
    output pool_pkg::act_t [LANES-1:0] ofm_wr_data,
    output logic                       ofm_wr_valid,
    input  logic                       ofm_wr_ready
);

    pool_cfg_if cfg_if_i ();

    pool_ctrl ctrl_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_valid       (cfg_valid),
        .cfg_ready       (cfg_ready),
        .cfg_num_points  (cfg_num_points),
        .cfg_k           (cfg_k),
        .cfg_map_base    (cfg_map_base),
        .cfg_ofm_rd_base (cfg_ofm_rd_base),
        .cfg_ofm_wr_base (cfg_ofm_wr_base),
        .cfg             (cfg_if_i.ctrl)
    );

    pool_map_reader map_reader_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .cfg               (cfg_if_i.dp),
        .map_rd_addr       (map_rd_addr),
        .map_rd_addr_valid (map_rd_addr_valid),
        .map_rd_addr_ready (map_rd_addr_ready),
        .map_rd_data       (map_rd_data),
        .map_rd_data_valid (map_rd_data_valid),
        .map_rd_data_ready (map_rd_data_ready),
        .ofm_rd_addr       (ofm_rd_addr),
        .ofm_rd_addr_valid (ofm_rd_addr_valid),
        .ofm_rd_addr_ready (ofm_rd_addr_ready)
    );

    pool_max_unit #(
        .LANES (LANES)
    ) max_unit_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .cfg               (cfg_if_i.dp),
        .ofm_rd_data       (ofm_rd_data),
        .ofm_rd_data_valid (ofm_rd_data_valid),
        .ofm_rd_data_ready (ofm_rd_data_ready),
        .ofm_wr_addr       (ofm_wr_addr),
        .ofm_wr_data       (ofm_wr_data),
        .ofm_wr_valid      (ofm_wr_valid),
        .ofm_wr_ready      (ofm_wr_ready)
    );

endmodule

// File: dv/pool_assert.sv
// Pooling engine handshake assertions
`timescale 1ns/1ps

module pool_assert #(
    parameter int LANES = 8
) (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       cfg_ready,
    input pool_pkg::idx_t             map_rd_addr,
    input logic                       map_rd_addr_valid,
    input logic                       map_rd_addr_ready,
    input pool_pkg::idx_t             ofm_rd_addr,
    input logic                       ofm_rd_addr_valid,
    input logic                       ofm_rd_addr_ready,
    input pool_pkg::idx_t             ofm_wr_addr,
    input pool_pkg::act_t [LANES-1:0] ofm_wr_data,
    input logic                       ofm_wr_valid,
    input logic                       ofm_wr_ready
);

    // ==================================================
    // Valid holds with a stable payload until ready
    // ==================================================

    map_addr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        map_rd_addr_valid && !map_rd_addr_ready |=> map_rd_addr_valid && $stable(map_rd_addr)
    ) else $error("map_rd_addr dropped or changed before ready");

    ofm_rd_addr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        ofm_rd_addr_valid && !ofm_rd_addr_ready |=> ofm_rd_addr_valid && $stable(ofm_rd_addr)
    ) else $error("ofm_rd_addr dropped or changed before ready");

    ofm_wr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        ofm_wr_valid && !ofm_wr_ready |=>
            ofm_wr_valid && $stable(ofm_wr_addr) && $stable(ofm_wr_data)
    ) else $error("ofm_wr dropped or changed before ready");

    // No new job while a result is still pending
    cfg_blocked_by_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        ofm_wr_valid |-> !cfg_ready
    ) else $error("cfg_ready high with an output write pending");

endmodule

// File: dv/pool_tb.sv
// Pooling engine testbench
`timescale 1ns/1ps

module pool_tb;
    import pool_pkg::*;

    localparam int LANES           = 8;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_JOBS        = 6;
    localparam int MAX_POINTS      = 8;
    localparam int WATCHDOG_CYCLES = NUM_JOBS * MAX_POINTS * (MAX_K + 4) * 20;
    localparam int MAP_DEPTH       = 64;
    localparam int FEAT_DEPTH      = 256;

    typedef act_t [LANES-1:0] row_t;

    logic      clk;
    logic      rst_n;
    logic      cfg_valid;
    logic      cfg_ready;
    idx_t      cfg_num_points;
    k_t        cfg_k;
    idx_t      cfg_map_base;
    idx_t      cfg_ofm_rd_base;
    idx_t      cfg_ofm_wr_base;
    idx_t      map_rd_addr;
    logic      map_rd_addr_valid;
    logic      map_rd_addr_ready;
    map_word_t map_rd_data;
    logic      map_rd_data_valid;
    logic      map_rd_data_ready;
    idx_t      ofm_rd_addr;
    logic      ofm_rd_addr_valid;
    logic      ofm_rd_addr_ready;
    row_t      ofm_rd_data;
    logic      ofm_rd_data_valid;
    logic      ofm_rd_data_ready;
    idx_t      ofm_wr_addr;
    row_t      ofm_wr_data;
    logic      ofm_wr_valid;
    logic      ofm_wr_ready;

    // Memory models and pending read addresses
    map_word_t map_mem [0:MAP_DEPTH-1];
    row_t      feat_mem [0:FEAT_DEPTH-1];
    idx_t      map_q [$];
    idx_t      feat_q [$];

    // Current job for the reference and the compare process
    k_t   job_k;
    idx_t job_points;
    idx_t job_map_base;
    idx_t job_rd_base;
    idx_t job_wr_base;
    int   exp_point;

    logic [31:0] lfsr_state;
    logic        stall_mode;
    int          error_count;
    int          write_count;

    pool_top #(
        .LANES (LANES)
    ) pool_top_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .cfg_valid         (cfg_valid),
        .cfg_ready         (cfg_ready),
        .cfg_num_points    (cfg_num_points),
        .cfg_k             (cfg_k),
        .cfg_map_base      (cfg_map_base),
        .cfg_ofm_rd_base   (cfg_ofm_rd_base),
        .cfg_ofm_wr_base   (cfg_ofm_wr_base),
        .map_rd_addr       (map_rd_addr),
        .map_rd_addr_valid (map_rd_addr_valid),
        .map_rd_addr_ready (map_rd_addr_ready),
        .map_rd_data       (map_rd_data),
        .map_rd_data_valid (map_rd_data_valid),
        .map_rd_data_ready (map_rd_data_ready),
        .ofm_rd_addr       (ofm_rd_addr),
        .ofm_rd_addr_valid (ofm_rd_addr_valid),
        .ofm_rd_addr_ready (ofm_rd_addr_ready),
        .ofm_rd_data       (ofm_rd_data),
        .ofm_rd_data_valid (ofm_rd_data_valid),
        .ofm_rd_data_ready (ofm_rd_data_ready),
        .ofm_wr_addr       (ofm_wr_addr),
        .ofm_wr_data       (ofm_wr_data),
        .ofm_wr_valid      (ofm_wr_valid),
        .ofm_wr_ready      (ofm_wr_ready)
    );

    bind pool_top pool_assert #(
        .LANES (LANES)
    ) assert_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .cfg_ready         (cfg_ready),
        .map_rd_addr       (map_rd_addr),
        .map_rd_addr_valid (map_rd_addr_valid),
        .map_rd_addr_ready (map_rd_addr_ready),
        .ofm_rd_addr       (ofm_rd_addr),
        .ofm_rd_addr_valid (ofm_rd_addr_valid),
        .ofm_rd_addr_ready (ofm_rd_addr_ready),
        .ofm_wr_addr       (ofm_wr_addr),
        .ofm_wr_data       (ofm_wr_data),
        .ofm_wr_valid      (ofm_wr_valid),
        .ofm_wr_ready      (ofm_wr_ready)
    );

    always #4 clk = ~clk;

    // ==================================================
    // Random source and helpers
    // ==================================================

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_bit()};
        end
        return val;
    endfunction

    // High about three cycles in four under back-pressure
    function automatic logic draw_enable();
        logic en;
        if (stall_mode) begin
            en = (take_bits(2) != 0);
        end else begin
            en = 1'b1;
        end
        return en;
    endfunction

    // Lane-wise max over the first K rows named by the point's map word
    function automatic row_t ref_max(input int p);
        map_word_t word;
        row_t      row;
        row_t      best;
        word = map_mem[job_map_base + p];
        best = '0;
        for (int i = 0; i < int'(job_k); i++) begin
            row = feat_mem[job_rd_base + word[i]];
            for (int l = 0; l < LANES; l++) begin
                if (row[l] > best[l]) begin
                    best[l] = row[l];
                end
            end
        end
        return best;
    endfunction

    task automatic report_mismatch(input string sig, input logic [255:0] got,
                                   input logic [255:0] exp);
        $display("Mismatch at %0t: %s got %0h expected %0h", $time, sig, got, exp);
        error_count++;
    endtask

    task automatic fill_map(input k_t k, input idx_t points, input idx_t base);
        map_word_t word;
        for (int p = 0; p < int'(points); p++) begin
            for (int i = 0; i < MAX_K; i++) begin
                if (i < int'(k)) begin
                    word[i] = idx_t'(take_bits(6));
                end else begin
                    // Unused slots point far outside the feature memory
                    word[i] = 16'hff00 | idx_t'(take_bits(6));
                end
            end
            map_mem[base + p] = word;
        end
    endtask

    // ==================================================
    // Job sequence
    // ==================================================

    task automatic run_job(input k_t k, input idx_t points, input idx_t map_base,
                           input idx_t rd_base, input idx_t wr_base);
        int   writes;
        logic hs;
        job_k        = k;
        job_points   = points;
        job_map_base = map_base;
        job_rd_base  = rd_base;
        job_wr_base  = wr_base;
        exp_point    = 0;
        fill_map(k, points, map_base);
        @(posedge clk);
        #1;
        cfg_valid       = 1'b1;
        cfg_k           = k;
        cfg_num_points  = points;
        cfg_map_base    = map_base;
        cfg_ofm_rd_base = rd_base;
        cfg_ofm_wr_base = wr_base;
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk);
            hs = cfg_ready;
            @(posedge clk);
            #1;
        end
        cfg_valid = 1'b0;
        writes    = 0;
        while (writes < int'(points)) begin
            @(negedge clk);
            if (cfg_ready !== 1'b0) begin
                report_mismatch("cfg_ready", cfg_ready, 1'b0);
            end
            if (ofm_wr_valid && ofm_wr_ready) begin
                writes++;
            end
        end
        @(negedge clk);
        if (cfg_ready !== 1'b1) begin
            report_mismatch("cfg_ready", cfg_ready, 1'b1);
        end
        if (exp_point != int'(points)) begin
            $display("Job with K=%0d wrote %0d of %0d results", k, exp_point, points);
            error_count++;
        end
    endtask

    initial begin
        clk               = 1'b0;
        rst_n             = 1'b0;
        cfg_valid         = 1'b0;
        cfg_num_points    = '0;
        cfg_k             = '0;
        cfg_map_base      = '0;
        cfg_ofm_rd_base   = '0;
        cfg_ofm_wr_base   = '0;
        map_rd_addr_ready = 1'b0;
        map_rd_data       = '0;
        map_rd_data_valid = 1'b0;
        ofm_rd_addr_ready = 1'b0;
        ofm_rd_data       = '0;
        ofm_rd_data_valid = 1'b0;
        ofm_wr_ready      = 1'b0;
        lfsr_state        = 32'hc094;
        stall_mode        = 1'b0;
        error_count       = 0;
        write_count       = 0;
        exp_point         = 0;
        job_points        = '0;
        for (int r = 0; r < FEAT_DEPTH; r++) begin
            for (int l = 0; l < LANES; l++) begin
                feat_mem[r][l] = act_t'(take_bits(ACT_WIDTH));
            end
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (cfg_ready !== 1'b1) begin
            report_mismatch("cfg_ready", cfg_ready, 1'b1);
        end
        if (map_rd_addr_valid !== 1'b0) begin
            report_mismatch("map_rd_addr_valid", map_rd_addr_valid, 1'b0);
        end
        if (ofm_rd_addr_valid !== 1'b0) begin
            report_mismatch("ofm_rd_addr_valid", ofm_rd_addr_valid, 1'b0);
        end
        if (ofm_wr_valid !== 1'b0) begin
            report_mismatch("ofm_wr_valid", ofm_wr_valid, 1'b0);
        end

        run_job(16, 8, 0, 0, 100);
        run_job(1, 8, 8, 64, 200);
        run_job(5, 8, 16, 128, 300);
        stall_mode = 1'b1;
        run_job(16, 8, 24, 192, 400);
        run_job(5, 8, 32, 0, 500);
        run_job(1, 6, 40, 64, 600);

        repeat (4) @(posedge clk);
        $display("Errors: %0d, results checked: %0d", error_count, write_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // ==================================================
    // Memory models with in-order read return
    // ==================================================

    always begin : memory_model
        logic map_addr_hs;
        logic map_data_hs;
        logic feat_addr_hs;
        logic feat_data_hs;
        @(negedge clk);
        map_addr_hs  = map_rd_addr_valid && map_rd_addr_ready;
        map_data_hs  = map_rd_data_valid && map_rd_data_ready;
        feat_addr_hs = ofm_rd_addr_valid && ofm_rd_addr_ready;
        feat_data_hs = ofm_rd_data_valid && ofm_rd_data_ready;
        // Only one map read in flight, so its data is taken on arrival
        if (map_rd_data_valid && !map_rd_data_ready) begin
            $display("Map data at %0t was not accepted in the cycle it arrived", $time);
            error_count++;
        end
        // A stalled result write blocks feature row intake
        if (ofm_wr_valid && !ofm_wr_ready && ofm_rd_data_ready !== 1'b0) begin
            report_mismatch("ofm_rd_data_ready", ofm_rd_data_ready, 1'b0);
        end
        if (map_addr_hs) begin
            if (map_rd_addr >= MAP_DEPTH) begin
                $display("Map read at %0t outside the map memory, address %0h",
                         $time, map_rd_addr);
                error_count++;
            end
            map_q.push_back(map_rd_addr % MAP_DEPTH);
        end
        if (feat_addr_hs) begin
            if (ofm_rd_addr >= FEAT_DEPTH) begin
                $display("Feature read at %0t outside the feature memory, address %0h",
                         $time, ofm_rd_addr);
                error_count++;
            end
            feat_q.push_back(ofm_rd_addr % FEAT_DEPTH);
        end
        @(posedge clk);
        #1;
        if (map_data_hs) begin
            map_rd_data_valid = 1'b0;
        end
        if (feat_data_hs) begin
            ofm_rd_data_valid = 1'b0;
        end
        if (!map_rd_data_valid && map_q.size() > 0 && draw_enable()) begin
            map_rd_data       = map_mem[map_q.pop_front()];
            map_rd_data_valid = 1'b1;
        end
        if (!ofm_rd_data_valid && feat_q.size() > 0 && draw_enable()) begin
            ofm_rd_data       = feat_mem[feat_q.pop_front()];
            ofm_rd_data_valid = 1'b1;
        end
        map_rd_addr_ready = draw_enable();
        ofm_rd_addr_ready = draw_enable();
        ofm_wr_ready      = draw_enable();
    end

    // ==================================================
    // Output write compare
    // ==================================================

    always begin : compare
        row_t exp_row;
        idx_t exp_addr;
        @(negedge clk);
        if (ofm_wr_valid && ofm_wr_ready) begin
            if (exp_point >= int'(job_points)) begin
                $display("Unexpected output write at %0t to address %0h", $time, ofm_wr_addr);
                error_count++;
            end else begin
                exp_row  = ref_max(exp_point);
                exp_addr = job_wr_base + idx_t'(exp_point);
                if (ofm_wr_addr !== exp_addr) begin
                    report_mismatch("ofm_wr_addr", ofm_wr_addr, exp_addr);
                end
                if (ofm_wr_data !== exp_row) begin
                    report_mismatch("ofm_wr_data", ofm_wr_data, exp_row);
                end
            end
            exp_point++;
            write_count++;
        end
    end

    // Watchdog
    initial begin
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, jobs did not complete", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: all.f
rtl/pool_pkg.sv
rtl/pool_cfg_if.sv
rtl/pool_ctrl.sv
rtl/pool_map_reader.sv
rtl/pool_max_unit.sv
rtl/pool_top.sv
dv/pool_assert.sv
dv/pool_tb.sv
